// ==== common/rx_queue_pkg.sv ====
// shared definitions for the ethernet receive queue
// byte, word, control and length types
// queue limits and fifo sizing
// state encodings for ingress and egress FSMs

package rx_queue_pkg;

   // ==============================
   // sizes and limits
   // ==============================
   localparam int bytes_per_word    = 8;
   // frames are cut when the written count reaches max_pkt_bytes - 2
   localparam int max_pkt_bytes     = 256;
   localparam int data_fifo_depth   = 64;
   localparam int max_pkt_words     = 32;
   // room for one max size packet must remain at frame start
   localparam int almost_full_level = data_fifo_depth - max_pkt_words;
   localparam int status_fifo_depth = 64;

   // ==============================
   // types
   // ==============================
   typedef logic [7:0]  byte_t;
   typedef logic [63:0] data_word_t;
   // bit 7 is the lane of data bits 63:56, the first byte of a word
   typedef logic [7:0]  ctrl_word_t;
   typedef logic [2:0]  lane_t;
   typedef logic [10:0] pkt_len_t;
   typedef logic [7:0]  word_len_t;
   // ctrl over data
   typedef logic [71:0] fifo_entry_t;
   // good flag over byte length
   typedef logic [11:0] status_t;

   // ctrl value of a length header word
   localparam ctrl_word_t hdr_ctrl = 8'hff;

   typedef enum logic [2:0] {
      rx_idle,
      rx_rcv_pkt,
      rx_wait_verdict,
      rx_add_pad,
      rx_drop_pkt
   } rx_state_t;

   typedef enum logic [1:0] {
      out_wait_pkt,
      out_header,
      out_pkt_body
   } out_state_t;

endpackage

// ==== rx_ingress/rx_byte_counter.sv ====
// byte counter for the frame being written
// includes pad bytes, gives lane and truncation flag

`timescale 1ns/100ps

module rx_byte_counter (
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   wr_byte,
   input  logic                   clear,
   output rx_queue_pkg::pkt_len_t byte_cnt,
   output rx_queue_pkg::lane_t    lane,
   output logic                   at_limit
);
   import rx_queue_pkg::*;

   // lane of the next byte is the low bits of the count
   assign lane = byte_cnt[$bits(lane_t)-1:0];

   // truncation point, two short of the max
   assign at_limit = byte_cnt >= pkt_len_t'(max_pkt_bytes - 2);

   always_ff @(posedge clk) begin
      if (reset) begin
         byte_cnt <= '0;
      end else if (clear) begin
         byte_cnt <= '0;
      end else if (wr_byte) begin
         byte_cnt <= byte_cnt + 1'b1;
      end
   end

endmodule

// ==== rx_ingress/rx_word_packer.sv ====
// input register stage for mac data and valid
// byte to word assembly with per-lane end marks
// word push toward the data FIFO

`timescale 1ns/100ps

module rx_word_packer (
   input  logic                      clk,
   input  logic                      reset,
   input  rx_queue_pkg::byte_t       rx_data,
   input  logic                      rx_dvld,
   input  logic                      wr_byte,
   input  logic                      eop,
   input  logic                      pad,
   output logic                      dvld_d1,
   output logic                      push,
   output rx_queue_pkg::fifo_entry_t entry
);
   import rx_queue_pkg::*;

   byte_t      data_d1;
   byte_t      wr_data;
   lane_t      lane_q;
   data_word_t word_q;
   ctrl_word_t ctrl_q;

   assign wr_data = pad ? '0 : data_d1;
   assign entry   = {ctrl_q, word_q};

   // ==============================
   // input register
   // ==============================
   always_ff @(posedge clk) begin
      data_d1 <= rx_data;
      if (reset) begin
         dvld_d1 <= 1'b0;
      end else begin
         dvld_d1 <= rx_dvld;
      end
   end

   // ==============================
   // word assembly
   // ==============================
   // lane 0 lands in bits 63:56, ctrl bit 7
   always_ff @(posedge clk) begin
      if (wr_byte) begin
         word_q[(7 - lane_q) * 8 +: 8] <= wr_data;
         if (lane_q == '0) begin
            ctrl_q <= {eop, 7'b0};
         end else begin
            ctrl_q[7 - lane_q] <= eop;
         end
      end
   end

   // lane tracks the counter through the same write strobe
   always_ff @(posedge clk) begin
      if (reset) begin
         lane_q <= '0;
         push   <= 1'b0;
      end else begin
         push <= wr_byte && (lane_q == lane_t'(bytes_per_word - 1));
         if (wr_byte) begin
            lane_q <= lane_q + 1'b1;
         end
      end
   end

endmodule

// ==== rx_ingress/rx_frame_fsm.sv ====
// ingress frame FSM
// accept or drop at frame start, eop marking, truncation
// verdict capture into the status FIFO, padding of the last word
// registered status pulses

`timescale 1ns/100ps

module rx_frame_fsm (
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  rx_dvld,
   input  logic                  dvld_d1,
   input  logic                  goodframe,
   input  logic                  badframe,
   input  logic                  queue_en,
   input  logic                  fifo_almost_full,
   input  rx_queue_pkg::pkt_len_t byte_cnt,
   input  rx_queue_pkg::lane_t   lane,
   input  logic                  at_limit,
   output logic                  wr_byte,
   output logic                  eop,
   output logic                  pad,
   output logic                  clear,
   output logic                  status_push,
   output rx_queue_pkg::status_t status_entry,
   output logic                  pkt_good,
   output logic                  pkt_bad,
   output logic                  pkt_dropped
);
   import rx_queue_pkg::*;

   rx_state_t state;
   rx_state_t state_nxt;
   logic      good_flag;
   logic      good_nxt;
   logic      bad_nxt;
   logic      drop_nxt;

   // length is the count before any pad bytes
   assign status_entry = {good_flag, byte_cnt};

   always_comb begin
      state_nxt   = state;
      wr_byte     = 1'b0;
      eop         = 1'b0;
      pad         = 1'b0;
      clear       = 1'b0;
      status_push = 1'b0;
      good_flag   = 1'b0;
      good_nxt    = 1'b0;
      bad_nxt     = 1'b0;
      drop_nxt    = 1'b0;

      case (state)
         rx_idle: begin
            if (dvld_d1) begin
               if (queue_en && !fifo_almost_full) begin
                  // first byte goes in now
                  wr_byte = 1'b1;
                  // single byte frame ends right here
                  if (!rx_dvld) begin
                     eop       = 1'b1;
                     state_nxt = rx_wait_verdict;
                  end else begin
                     state_nxt = rx_rcv_pkt;
                  end
               end else begin
                  drop_nxt  = 1'b1;
                  state_nxt = rx_drop_pkt;
               end
            end
         end

         rx_rcv_pkt: begin
            wr_byte = 1'b1;
            // raw valid low means this registered byte is the last
            if (!rx_dvld) begin
               eop       = 1'b1;
               state_nxt = rx_wait_verdict;
            end else if (at_limit) begin
               // too long, cut and report bad now
               eop         = 1'b1;
               status_push = 1'b1;
               bad_nxt     = 1'b1;
               state_nxt   = rx_add_pad;
            end
         end

         // verdict arrives some cycles after valid falls
         rx_wait_verdict: begin
            if (goodframe) begin
               status_push = 1'b1;
               good_flag   = 1'b1;
               good_nxt    = 1'b1;
               state_nxt   = rx_add_pad;
            end else if (badframe) begin
               status_push = 1'b1;
               bad_nxt     = 1'b1;
               state_nxt   = rx_add_pad;
            end
         end

         rx_add_pad: begin
            if (lane == '0) begin
               clear = 1'b1;
               // a truncated frame may still be arriving
               state_nxt = dvld_d1 ? rx_drop_pkt : rx_idle;
            end else begin
               wr_byte = 1'b1;
               pad     = 1'b1;
            end
         end

         // skip the rest of the frame
         rx_drop_pkt: begin
            if (!dvld_d1) begin
               state_nxt = rx_idle;
            end
         end

         default: state_nxt = rx_idle;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state       <= rx_idle;
         pkt_good    <= 1'b0;
         pkt_bad     <= 1'b0;
         pkt_dropped <= 1'b0;
      end else begin
         state       <= state_nxt;
         pkt_good    <= good_nxt;
         pkt_bad     <= bad_nxt;
         pkt_dropped <= drop_nxt;
      end
   end

endmodule

// ==== design/rx_sync_fifo.sv ====
// synchronous FIFO, first word fall through
// fill count with almost full threshold
// used for both packet words and packet status

`timescale 1ns/100ps

module rx_sync_fifo #(
   parameter int width = 72,
   parameter int depth = 64
) (
   input  logic             clk,
   input  logic             reset,
   input  logic             push,
   input  logic [width-1:0] push_data,
   input  logic             pop,
   output logic [width-1:0] pop_data,
   output logic             empty,
   output logic             almost_full,
   output logic             full
);
   import rx_queue_pkg::*;

   logic [width-1:0]         mem [depth];
   logic [$clog2(depth)-1:0] wr_ptr;
   logic [$clog2(depth)-1:0] rd_ptr;
   logic [$clog2(depth):0]   count;
   logic                     do_push;
   logic                     do_pop;

   assign do_push = push && !full;
   assign do_pop  = pop && !empty;

   // head is visible whenever not empty
   assign pop_data    = mem[rd_ptr];
   assign empty       = count == '0;
   assign full        = count == ($clog2(depth) + 1)'(depth);
   assign almost_full = count > ($clog2(depth) + 1)'(almost_full_level);

   always_ff @(posedge clk) begin
      if (do_push) begin
         mem[wr_ptr] <= push_data;
      end
   end

   // pointers wrap on the power of two depth
   always_ff @(posedge clk) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (do_pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({do_push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

endmodule

// ==== design/rx_out_fsm.sv ====
// egress FSM
// length header for good packets, body words under out_rdy
// bad packets popped and thrown away
// registered downstream outputs

`timescale 1ns/100ps

module rx_out_fsm (
   input  logic                      clk,
   input  logic                      reset,
   input  logic [15:0]               port_number,
   input  logic                      data_empty,
   input  rx_queue_pkg::fifo_entry_t data_head,
   input  logic                      status_empty,
   input  rx_queue_pkg::status_t     status_head,
   input  logic                      out_rdy,
   output logic                      data_pop,
   output logic                      status_pop,
   output rx_queue_pkg::data_word_t  out_data,
   output rx_queue_pkg::ctrl_word_t  out_ctrl,
   output logic                      out_wr
);
   import rx_queue_pkg::*;

   out_state_t state;
   out_state_t state_nxt;
   ctrl_word_t head_ctrl;
   data_word_t head_data;
   logic       head_good;
   pkt_len_t   head_len;
   logic       pkt_good_q;
   pkt_len_t   pkt_len_q;
   word_len_t  word_len;
   data_word_t header;
   data_word_t data_nxt;
   ctrl_word_t ctrl_nxt;
   logic       wr_nxt;

   assign {head_ctrl, head_data} = data_head;
   assign {head_good, head_len}  = status_head;

   // bytes to words, rounded up
   assign word_len = word_len_t'((12'(pkt_len_q) + 12'd7) >> 3);

   // word len 63:48, port 31:16, byte len 10:0
   assign header = {8'h00, word_len, 16'h0000, port_number, 5'b0, pkt_len_q};

   always_comb begin
      state_nxt  = state;
      status_pop = 1'b0;
      data_pop   = 1'b0;
      wr_nxt     = 1'b0;
      data_nxt   = head_data;
      ctrl_nxt   = head_ctrl;

      case (state)
         out_wait_pkt: begin
            if (!status_empty) begin
               status_pop = 1'b1;
               // bad packets skip the header
               state_nxt  = head_good ? out_header : out_pkt_body;
            end
         end

         out_header: begin
            data_nxt = header;
            ctrl_nxt = hdr_ctrl;
            if (out_rdy) begin
               wr_nxt    = 1'b1;
               state_nxt = out_pkt_body;
            end
         end

         out_pkt_body: begin
            // the last word may still be padding in
            if (!data_empty && (out_rdy || !pkt_good_q)) begin
               data_pop = 1'b1;
               wr_nxt   = pkt_good_q;
               if (|head_ctrl) begin
                  state_nxt = out_wait_pkt;
               end
            end
         end

         default: state_nxt = out_wait_pkt;
      endcase
   end

   // status is popped on entry, keep a copy
   always_ff @(posedge clk) begin
      if (status_pop) begin
         pkt_good_q <= head_good;
         pkt_len_q  <= head_len;
      end
      if (wr_nxt) begin
         out_data <= data_nxt;
         out_ctrl <= ctrl_nxt;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state  <= out_wait_pkt;
         out_wr <= 1'b0;
      end else begin
         state  <= state_nxt;
         out_wr <= wr_nxt;
      end
   end

endmodule

// ==== design/rx_queue.sv ====
// receive queue top level
// ingress packer, byte counter and frame FSM
// data word FIFO and status FIFO
// egress FSM toward the downstream module

`timescale 1ns/100ps

module rx_queue #(
   parameter int port_number = 0
) (
   input  logic                     clk,
   input  logic                     reset,
   // mac side
   input  rx_queue_pkg::byte_t      gmac_rx_data,
   input  logic                     gmac_rx_dvld,
   input  logic                     gmac_rx_goodframe,
   input  logic                     gmac_rx_badframe,
   input  logic                     rx_queue_en,
   // downstream side
   input  logic                     out_rdy,
   output rx_queue_pkg::data_word_t out_data,
   output rx_queue_pkg::ctrl_word_t out_ctrl,
   output logic                     out_wr,
   // status pulses
   output logic                     rx_pkt_good,
   output logic                     rx_pkt_bad,
   output logic                     rx_pkt_dropped
);
   import rx_queue_pkg::*;

   // ingress control
   logic        dvld_d1;
   logic        wr_byte;
   logic        eop;
   logic        pad;
   logic        clear;
   pkt_len_t    byte_cnt;
   lane_t       lane;
   logic        at_limit;

   // data fifo
   logic        data_push;
   fifo_entry_t data_entry;
   logic        data_pop;
   fifo_entry_t data_head;
   logic        data_empty;
   logic        data_almost_full;

   // status fifo
   logic        status_push;
   status_t     status_entry;
   logic        status_pop;
   status_t     status_head;
   logic        status_empty;

   // ==============================
   // ingress
   // ==============================
   rx_word_packer packer (
      .clk      (clk),
      .reset    (reset),
      .rx_data  (gmac_rx_data),
      .rx_dvld  (gmac_rx_dvld),
      .wr_byte  (wr_byte),
      .eop      (eop),
      .pad      (pad),
      .dvld_d1  (dvld_d1),
      .push     (data_push),
      .entry    (data_entry)
   );

   rx_byte_counter byte_counter (
      .clk      (clk),
      .reset    (reset),
      .wr_byte  (wr_byte),
      .clear    (clear),
      .byte_cnt (byte_cnt),
      .lane     (lane),
      .at_limit (at_limit)
   );

   rx_frame_fsm frame_fsm (
      .clk              (clk),
      .reset            (reset),
      .rx_dvld          (gmac_rx_dvld),
      .dvld_d1          (dvld_d1),
      .goodframe        (gmac_rx_goodframe),
      .badframe         (gmac_rx_badframe),
      .queue_en         (rx_queue_en),
      .fifo_almost_full (data_almost_full),
      .byte_cnt         (byte_cnt),
      .lane             (lane),
      .at_limit         (at_limit),
      .wr_byte          (wr_byte),
      .eop              (eop),
      .pad              (pad),
      .clear            (clear),
      .status_push      (status_push),
      .status_entry     (status_entry),
      .pkt_good         (rx_pkt_good),
      .pkt_bad          (rx_pkt_bad),
      .pkt_dropped      (rx_pkt_dropped)
   );

   // ==============================
   // storage
   // ==============================
   rx_sync_fifo #(
      .width ($bits(fifo_entry_t)),
      .depth (data_fifo_depth)
   ) data_fifo (
      .clk         (clk),
      .reset       (reset),
      .push        (data_push),
      .push_data   (data_entry),
      .pop         (data_pop),
      .pop_data    (data_head),
      .empty       (data_empty),
      .almost_full (data_almost_full),
      .full        ()
   );

   // status fifo never fills before the data fifo, threshold unused
   rx_sync_fifo #(
      .width ($bits(status_t)),
      .depth (status_fifo_depth)
   ) status_fifo (
      .clk         (clk),
      .reset       (reset),
      .push        (status_push),
      .push_data   (status_entry),
      .pop         (status_pop),
      .pop_data    (status_head),
      .empty       (status_empty),
      .almost_full (),
      .full        ()
   );

   // ==============================
   // egress
   // ==============================
   rx_out_fsm out_fsm (
      .clk          (clk),
      .reset        (reset),
      .port_number  (16'(port_number)),
      .data_empty   (data_empty),
      .data_head    (data_head),
      .status_empty (status_empty),
      .status_head  (status_head),
      .out_rdy      (out_rdy),
      .data_pop     (data_pop),
      .status_pop   (status_pop),
      .out_data     (out_data),
      .out_ctrl     (out_ctrl),
      .out_wr       (out_wr)
   );

endmodule

// ==== verification/rx_queue_props.sv ====
// bound checks for the receive queue
// FIFO push and pop legality
// FSM state encodings kept in range

`timescale 1ns/100ps

module rx_queue_props #(
   parameter int state_bits  = 3,
   parameter int state_count = 5
) (
   input logic                  clk,
   input logic                  reset,
   input logic                  push,
   input logic                  pop,
   input logic                  full,
   input logic                  empty,
   input logic [state_bits-1:0] state
);

   // raised by any failing property, polled from the testbench
   logic violation;

   initial violation = 1'b0;

   // ==============================
   // FIFO rules
   // ==============================
   no_push_when_full: assert property (@(posedge clk) disable iff (reset) !(push && full))
      else begin
         $error("push while FIFO full");
         violation = 1'b1;
      end

   no_pop_when_empty: assert property (@(posedge clk) disable iff (reset) !(pop && empty))
      else begin
         $error("pop while FIFO empty");
         violation = 1'b1;
      end

   // ==============================
   // FSM rules
   // ==============================
   // encodings above the last enum value are illegal
   legal_state: assert property (@(posedge clk) disable iff (reset)
                                 int'(state) < state_count)
      else begin
         $error("FSM in illegal state");
         violation = 1'b1;
      end

endmodule

// ==== verification/tb_rx_queue.sv ====
// testbench for the ethernet receive queue
// random frames from a fixed seed, reference model of packing and header
// output word and status pulse compares, cycle timeout

`timescale 1ns/100ps

module tb_rx_queue;
   import rx_queue_pkg::*;

   localparam int port_id      = 5;
   // mixed traffic under random out_rdy, then fill test with out_rdy low
   localparam int mixed_frames = 40;
   localparam int fill_frames  = 12;
   localparam int frame_count  = mixed_frames + fill_frames;

   logic       clk;
   logic       reset;
   byte_t      gmac_rx_data;
   logic       gmac_rx_dvld;
   logic       gmac_rx_goodframe;
   logic       gmac_rx_badframe;
   logic       rx_queue_en;
   logic       out_rdy;
   data_word_t out_data;
   ctrl_word_t out_ctrl;
   logic       out_wr;
   logic       rx_pkt_good;
   logic       rx_pkt_bad;
   logic       rx_pkt_dropped;

   // stimulus, all drawn at time zero
   int         seed;
   int         frame_len [frame_count];
   logic       frame_good [frame_count];
   logic       frame_en [frame_count];
   int         frame_delay [frame_count];
   byte_t      frame_bytes [$];
   int         byte_pos;

   // model state
   data_word_t exp_data [$];
   ctrl_word_t exp_ctrl [$];
   logic [2:0] exp_pulse [$];
   int         stored_words;
   logic       fill_check;
   logic       rdy_random;
   int         cycles;
   int         cycle_limit;

   rx_queue #(.port_number(port_id)) uut (
      .clk               (clk),
      .reset             (reset),
      .gmac_rx_data      (gmac_rx_data),
      .gmac_rx_dvld      (gmac_rx_dvld),
      .gmac_rx_goodframe (gmac_rx_goodframe),
      .gmac_rx_badframe  (gmac_rx_badframe),
      .rx_queue_en       (rx_queue_en),
      .out_rdy           (out_rdy),
      .out_data          (out_data),
      .out_ctrl          (out_ctrl),
      .out_wr            (out_wr),
      .rx_pkt_good       (rx_pkt_good),
      .rx_pkt_bad        (rx_pkt_bad),
      .rx_pkt_dropped    (rx_pkt_dropped)
   );

   bind rx_sync_fifo rx_queue_props #(.state_bits(1), .state_count(1)) fifo_props (
      .clk(clk), .reset(reset), .push(push), .pop(pop),
      .full(full), .empty(empty), .state(1'b0)
   );
   bind rx_frame_fsm rx_queue_props #(.state_bits(3), .state_count(5)) state_props (
      .clk(clk), .reset(reset), .push(1'b0), .pop(1'b0),
      .full(1'b0), .empty(1'b1), .state(state)
   );
   bind rx_out_fsm rx_queue_props #(.state_bits(2), .state_count(3)) state_props (
      .clk(clk), .reset(reset), .push(1'b0), .pop(1'b0),
      .full(1'b0), .empty(1'b1), .state(state)
   );

   always #20 clk = ~clk;

   // ==============================
   // failure and compare tasks
   // ==============================
   task automatic stop_with_failure(input string why);
      $display("%s", why);
      $display("Some tests failed");
      $fatal(1, "simulation stopped on first error");
   endtask

   task automatic check_word(input data_word_t got_data, input ctrl_word_t got_ctrl);
      data_word_t want_data;
      ctrl_word_t want_ctrl;
      if (exp_data.size() == 0) begin
         stop_with_failure("output word written while no good packet was expected");
      end else begin
         want_data = exp_data.pop_front();
         want_ctrl = exp_ctrl.pop_front();
         if (got_ctrl !== want_ctrl) begin
            stop_with_failure($sformatf("MISMATCH out_ctrl got %h expected %h",
                                        got_ctrl, want_ctrl));
         end else if (got_data !== want_data) begin
            stop_with_failure($sformatf("MISMATCH out_data got %h expected %h",
                                        got_data, want_data));
         end
      end
   endtask

   // pulses packed as good, bad, dropped
   task automatic check_pulse(input logic good, input logic bad, input logic dropped);
      logic [2:0] got;
      logic [2:0] want;
      got = {good, bad, dropped};
      if (exp_pulse.size() == 0) begin
         stop_with_failure("status pulse seen while no frame was pending");
      end else begin
         want = exp_pulse.pop_front();
         if (got !== want) begin
            stop_with_failure($sformatf("MISMATCH rx_pkt_good_bad_dropped got %h expected %h",
                                        got, want));
         end
      end
   endtask

   // ==============================
   // stimulus generation and model
   // ==============================
   task automatic make_frames();
      for (int f = 0; f < frame_count; f++) begin
         if (f < mixed_frames) begin
            frame_len[f] = 1 + int'($unsigned($random(seed)) % 300);
         end else begin
            // fill test stays below truncation
            frame_len[f] = 1 + int'($unsigned($random(seed)) % (max_pkt_bytes - 1));
         end
         frame_good[f]  = (($random(seed) & 1) != 0) || (f >= mixed_frames);
         frame_en[f]    = (($random(seed) & 7) != 0) || (f >= mixed_frames);
         frame_delay[f] = 1 + int'($unsigned($random(seed)) % 5);
      end
      // a few fixed cases up front
      frame_len[0] = 64;
      frame_good[0] = 1'b1;
      frame_en[0] = 1'b1;
      frame_len[1] = 17;
      frame_good[1] = 1'b0;
      frame_en[1] = 1'b1;
      frame_len[2] = 9;
      frame_good[2] = 1'b1;
      frame_en[2] = 1'b1;
      frame_len[3] = 30;
      frame_en[3] = 1'b0;
      frame_len[4] = 280;
      frame_good[4] = 1'b1;
      frame_en[4] = 1'b1;
      frame_len[5] = 1;
      frame_good[5] = 1'b1;
      frame_en[5] = 1'b1;
      frame_len[6] = max_pkt_bytes - 1;
      frame_good[6] = 1'b1;
      frame_en[6] = 1'b1;
      cycle_limit = 40 * frame_count;
      for (int f = 0; f < frame_count; f++) begin
         cycle_limit += frame_len[f];
         for (int i = 0; i < frame_len[f]; i++) begin
            frame_bytes.push_back(byte_t'($random(seed)));
         end
      end
   endtask

   task automatic model_frame(input int f);
      int         len;
      int         nwords;
      int         k;
      data_word_t word;
      ctrl_word_t ctrl;
      data_word_t hdr;
      len = frame_len[f];
      nwords = (len + bytes_per_word - 1) / bytes_per_word;
      if (!frame_en[f] || (fill_check && stored_words > almost_full_level)) begin
         exp_pulse.push_back(3'b001);
      end else if (len >= max_pkt_bytes) begin
         // raw valid runs one byte ahead, so only max_pkt_bytes and up get cut
         exp_pulse.push_back(3'b010);
         stored_words += max_pkt_words;
      end else if (!frame_good[f]) begin
         exp_pulse.push_back(3'b010);
         stored_words += nwords;
      end else begin
         exp_pulse.push_back(3'b100);
         stored_words += nwords;
         hdr = '0;
         hdr[63:48] = 16'(nwords);
         hdr[31:16] = 16'(port_id);
         hdr[10:0] = 11'(len);
         exp_data.push_back(hdr);
         exp_ctrl.push_back(hdr_ctrl);
         for (int w = 0; w < nwords; w++) begin
            word = '0;
            ctrl = '0;
            // first byte of a word in the top lane
            for (int l = 0; l < bytes_per_word; l++) begin
               k = w * bytes_per_word + l;
               if (k < len) begin
                  word[(7 - l) * 8 +: 8] = frame_bytes[byte_pos + k];
               end
               if (k == len - 1) begin
                  ctrl[7 - l] = 1'b1;
               end
            end
            exp_data.push_back(word);
            exp_ctrl.push_back(ctrl);
         end
      end
   endtask

   // called on a falling edge
   task automatic send_frame(input int f);
      rx_queue_en = frame_en[f];
      for (int i = 0; i < frame_len[f]; i++) begin
         gmac_rx_dvld = 1'b1;
         gmac_rx_data = frame_bytes[byte_pos + i];
         @(negedge clk);
      end
      gmac_rx_dvld = 1'b0;
      gmac_rx_data = '0;
      repeat (frame_delay[f]) @(negedge clk);
      gmac_rx_goodframe = frame_good[f];
      gmac_rx_badframe  = !frame_good[f];
      @(negedge clk);
      gmac_rx_goodframe = 1'b0;
      gmac_rx_badframe  = 1'b0;
      repeat (12) @(negedge clk);
      byte_pos += frame_len[f];
   endtask

   task automatic wait_drained();
      while (exp_data.size() != 0 || exp_pulse.size() != 0) begin
         @(negedge clk);
      end
   endtask

   // ==============================
   // monitors, ready driver, timeout
   // ==============================
   always @(negedge clk) begin
      if (!reset) begin
         if (out_wr) begin
            check_word(out_data, out_ctrl);
         end
         if (rx_pkt_good || rx_pkt_bad || rx_pkt_dropped) begin
            check_pulse(rx_pkt_good, rx_pkt_bad, rx_pkt_dropped);
         end
         if (uut.data_fifo.fifo_props.violation || uut.status_fifo.fifo_props.violation ||
             uut.frame_fsm.state_props.violation || uut.out_fsm.state_props.violation) begin
            stop_with_failure("a bound FIFO or FSM property failed");
         end
      end
   end

   // random ready most of the time, held low for the fill test
   initial begin
      out_rdy = 1'b0;
      forever begin
         @(negedge clk);
         out_rdy = rdy_random && (($random(seed) & 3) != 0);
      end
   end

   initial begin
      cycles = 0;
      while (cycles <= cycle_limit) begin
         @(posedge clk);
         cycles++;
      end
      stop_with_failure($sformatf("run did not finish within %0d cycles", cycle_limit));
   end

   // ==============================
   // test sequence
   // ==============================
   initial begin
      clk = 1'b0;
      reset = 1'b1;
      gmac_rx_data = '0;
      gmac_rx_dvld = 1'b0;
      gmac_rx_goodframe = 1'b0;
      gmac_rx_badframe = 1'b0;
      rx_queue_en = 1'b0;
      rdy_random = 1'b1;
      stored_words = 0;
      fill_check = 1'b0;
      byte_pos = 0;
      seed = 32'hb5b6bb7a;
      make_frames();
      repeat (3) @(negedge clk);
      reset = 1'b0;
      repeat (2) @(negedge clk);
      for (int f = 0; f < mixed_frames; f++) begin
         model_frame(f);
         send_frame(f);
      end
      wait_drained();
      // let trailing bad packets be discarded
      repeat (64) @(negedge clk);
      rdy_random = 1'b0;
      fill_check = 1'b1;
      stored_words = 0;
      for (int f = mixed_frames; f < frame_count; f++) begin
         model_frame(f);
         send_frame(f);
      end
      rdy_random = 1'b1;
      wait_drained();
      repeat (20) @(negedge clk);
      // every stored word and status belongs to a delivered packet
      if (!uut.data_empty || !uut.status_empty) begin
         stop_with_failure("words or status left in the FIFOs after the last packet");
      end else begin
         $display("All tests passed");
         $finish;
      end
   end

endmodule

// ==== vlog.f ====
common/rx_queue_pkg.sv
rx_ingress/rx_byte_counter.sv
rx_ingress/rx_word_packer.sv
rx_ingress/rx_frame_fsm.sv
design/rx_sync_fifo.sv
design/rx_out_fsm.sv
design/rx_queue.sv
verification/rx_queue_props.sv
verification/tb_rx_queue.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_rx_queue
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+100

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS)

clean:
	rm -rf $(BUILD_DIR)
